// ==== Makefile ====
VERILATOR = verilator
COMMON    = --timing --timescale 1ns/1ns
FLAGS     = --binary --assert $(COMMON)
TOP       = mem_stage_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_TEXT = Finished with errors
PASS_TEXT = Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(COMMON) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_cfg.svh"

module cp0_regs (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    wr_data,
    input  mem_stage_pkg::cp0_reg_e regnum,
    input  logic                    mtc0,
    input  logic                    eret,
    input  logic [`MEM_XLEN-1:0]    curr_pc,
    input  logic [7:0]              interrupt_sources,
    input  logic                    overflow,
    input  logic                    reserved_inst,
    input  logic                    syscall,
    output logic [`MEM_XLEN-1:0]    rd_data,
    output logic [`MEM_XLEN-1:0]    epc,
    output logic                    taken_handler
);
    logic [`MEM_XLEN-1:0]     status;
    logic [`MEM_XLEN-1:0]     cause;
    logic                     exl;
    logic                     ie;
    logic [7:0]               im;
    logic                     exc_any;
    logic                     irq;
    mem_stage_pkg::exc_code_e exc_code;

    assign exl = status[`CP0_EXL_BIT];
    assign ie  = status[`CP0_IE_BIT];
    assign im  = status[`CP0_IM_LSB +: 8];

    assign exc_any = overflow | reserved_inst | syscall;
    assign irq     = ie && (|(interrupt_sources & im));

    // nothing is taken while already in the handler
    assign taken_handler = !exl && (exc_any || irq);

    // exceptions first, overflow highest
    always_comb begin
        if (overflow) begin
            exc_code = mem_stage_pkg::EXC_OVERFLOW;
        end else if (reserved_inst) begin
            exc_code = mem_stage_pkg::EXC_RESERVED;
        end else if (syscall) begin
            exc_code = mem_stage_pkg::EXC_SYSCALL;
        end else begin
            exc_code = mem_stage_pkg::EXC_INT;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status <= '0;
            cause  <= '0;
            epc    <= '0;
        end else if (taken_handler) begin
            epc                 <= curr_pc;
            status[`CP0_EXL_BIT] <= 1'b1;
            cause[6:2]          <= exc_code;
        end else begin
            if (mtc0) begin
                case (regnum)
                    mem_stage_pkg::CP0_STATUS: status <= wr_data;
                    mem_stage_pkg::CP0_CAUSE:  cause  <= wr_data;
                    mem_stage_pkg::CP0_EPC:    epc    <= wr_data;
                    default: ;
                endcase
            end
            // eret wins over a status write on the EXL bit
            if (eret) begin
                status[`CP0_EXL_BIT] <= 1'b0;
            end
        end
    end

    // pending interrupt lines show live in cause 15:8
    always_comb begin
        case (regnum)
            mem_stage_pkg::CP0_STATUS: rd_data = status;
            mem_stage_pkg::CP0_CAUSE:  rd_data = {cause[63:16], interrupt_sources, cause[7:0]};
            mem_stage_pkg::CP0_EPC:    rd_data = epc;
            default:                   rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_cfg.svh"

module data_mem (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`MEM_XLEN-1:0]       addr,
    input  logic [`MEM_XLEN-1:0]       store_data,
    input  mem_stage_pkg::load_e       load_type,
    input  logic                       load_signed,
    input  mem_stage_pkg::store_e      store_type,
    input  logic                       flush,
    input  logic                       periph_hit,
    input  logic [`MEM_XLEN-1:0]       periph_rdata,
    input  logic [`MEM_XLEN-1:0]       fetch_pc,
    output logic [`MEM_XLEN-1:0]       load_data,
    output logic [31:0]                inst
);
    localparam int AW = $clog2(`DMEM_BYTES);

    logic [7:0]          mem [`DMEM_BYTES];
    logic [AW-1:0]       base;
    logic [AW-1:0]       pc_base;
    logic [`MEM_XLEN-1:0] raw;
    logic [`MEM_XLEN-1:0] src;
    logic [3:0]          store_bytes;
    logic                store_en;

    // byte offsets wrap modulo the memory size
    assign base    = addr[AW-1:0];
    assign pc_base = fetch_pc[AW-1:0];

    // gather eight little-endian bytes starting at the access address
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = mem[base + AW'(i)];
        end
    end

    // instruction port, one word at fetch_pc
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            inst[8*i +: 8] = mem[pc_base + AW'(i)];
        end
    end

    // the peripheral owns the access on a hit
    assign src = periph_hit ? periph_rdata : raw;

    // size and extend the loaded field
    always_comb begin
        case (load_type)
            mem_stage_pkg::LOAD_BYTE:
                load_data = {{56{load_signed & src[7]}}, src[7:0]};
            mem_stage_pkg::LOAD_HALF:
                load_data = {{48{load_signed & src[15]}}, src[15:0]};
            mem_stage_pkg::LOAD_WORD:
                load_data = {{32{load_signed & src[31]}}, src[31:0]};
            default:
                load_data = src;
        endcase
    end

    always_comb begin
        case (store_type)
            mem_stage_pkg::STORE_BYTE:   store_bytes = 4'd1;
            mem_stage_pkg::STORE_HALF:   store_bytes = 4'd2;
            mem_stage_pkg::STORE_WORD:   store_bytes = 4'd4;
            mem_stage_pkg::STORE_DOUBLE: store_bytes = 4'd8;
            default:                     store_bytes = 4'd0;
        endcase
    end

    // squashed or peripheral stores leave the array alone
    assign store_en = (store_bytes != 4'd0) && !flush && !periph_hit;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (store_en) begin
            for (int i = 0; i < 8; i++) begin
                if (4'(i) < store_bytes) begin
                    mem[base + AW'(i)] <= store_data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_result_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`MEM_XLEN-1:0]  alu_out,
    input  logic [`MEM_XLEN-1:0]  load_data,
    input  logic [`MEM_XLEN-1:0]  cp0_rdata,
    input  logic [`MEM_XLEN-1:0]  epc,
    input  logic [`MEM_XLEN-1:0]  pc4,
    input  logic                  taken_handler,
    input  mem_stage_pkg::load_e  load_type,
    input  logic                  mfc0,
    input  logic                  link,
    input  logic [4:0]            w_regnum,
    input  logic                  write_enable,
    output logic [`MEM_XLEN-1:0]  w_data,
    output logic [4:0]            w_regnum_q,
    output logic                  write_enable_q,
    output logic [`MEM_XLEN-1:0]  epc_q,
    output logic                  taken_handler_q
);
    logic [`MEM_XLEN-1:0] w_next;
    logic                 is_load;

    assign is_load = (load_type != mem_stage_pkg::LOAD_NONE);

    // link beats mfc0, mfc0 beats a load, alu result otherwise
    always_comb begin
        if (link) begin
            w_next = pc4;
        end else if (mfc0) begin
            w_next = cp0_rdata;
        end else if (is_load) begin
            w_next = load_data;
        end else begin
            w_next = alu_out;
        end
    end

    // stage register toward writeback
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            w_data          <= '0;
            w_regnum_q      <= '0;
            write_enable_q  <= 1'b0;
            epc_q           <= '0;
            taken_handler_q <= 1'b0;
        end else begin
            w_data          <= w_next;
            w_regnum_q      <= w_regnum;
            write_enable_q  <= write_enable;
            epc_q           <= epc;
            taken_handler_q <= taken_handler;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`MEM_XLEN-1:0]    alu_out,
    input  logic [`MEM_XLEN-1:0]    store_data,
    input  mem_stage_pkg::load_e    load_type,
    input  logic                    load_signed,
    input  mem_stage_pkg::store_e   store_type,
    input  logic [4:0]              w_regnum,
    input  logic                    write_enable,
    input  logic                    mfc0,
    input  logic                    mtc0,
    input  mem_stage_pkg::cp0_reg_e cp0_reg,
    input  logic                    link,
    input  logic [`MEM_XLEN-1:0]    pc,
    input  logic [`MEM_XLEN-1:0]    pc4,
    input  logic                    overflow,
    input  logic                    reserved_inst,
    input  logic                    syscall,
    input  logic [`MEM_XLEN-1:0]    fetch_pc,
    input  logic [7:0]              interrupt_sources,
    input  logic                    flush,
    input  logic                    eret,
    input  logic                    periph_hit,
    input  logic [`MEM_XLEN-1:0]    periph_rdata,
    output logic [31:0]             inst,
    output logic [`MEM_XLEN-1:0]    w_data,
    output logic [4:0]              w_regnum_q,
    output logic                    write_enable_q,
    output logic [`MEM_XLEN-1:0]    epc_q,
    output logic                    taken_handler_q
);
    logic [`MEM_XLEN-1:0] load_data;
    logic [`MEM_XLEN-1:0] cp0_rdata;
    logic [`MEM_XLEN-1:0] epc;
    logic                 taken_handler;

    // the alu result doubles as the memory address
    data_mem dmem0 (
        .clock        (clock),
        .reset        (reset),
        .addr         (alu_out),
        .store_data   (store_data),
        .load_type    (load_type),
        .load_signed  (load_signed),
        .store_type   (store_type),
        .flush        (flush),
        .periph_hit   (periph_hit),
        .periph_rdata (periph_rdata),
        .fetch_pc     (fetch_pc),
        .load_data    (load_data),
        .inst         (inst)
    );

    cp0_regs cp0_0 (
        .clock             (clock),
        .reset             (reset),
        .wr_data           (store_data),
        .regnum            (cp0_reg),
        .mtc0              (mtc0),
        .eret              (eret),
        .curr_pc           (pc),
        .interrupt_sources (interrupt_sources),
        .overflow          (overflow),
        .reserved_inst     (reserved_inst),
        .syscall           (syscall),
        .rd_data           (cp0_rdata),
        .epc               (epc),
        .taken_handler     (taken_handler)
    );

    mem_result_stage result0 (
        .clock           (clock),
        .reset           (reset),
        .alu_out         (alu_out),
        .load_data       (load_data),
        .cp0_rdata       (cp0_rdata),
        .epc             (epc),
        .pc4             (pc4),
        .taken_handler   (taken_handler),
        .load_type       (load_type),
        .mfc0            (mfc0),
        .link            (link),
        .w_regnum        (w_regnum),
        .write_enable    (write_enable),
        .w_data          (w_data),
        .w_regnum_q      (w_regnum_q),
        .write_enable_q  (write_enable_q),
        .epc_q           (epc_q),
        .taken_handler_q (taken_handler_q)
    );

endmodule

`default_nettype wire

// ==== logic/mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// datapath and address width
`define MEM_XLEN 64

// unified memory size in bytes, addresses wrap at this size
`define DMEM_BYTES 2048

// status register bit positions
`define CP0_IE_BIT 0
`define CP0_EXL_BIT 1
`define CP0_IM_LSB 8

`endif

// ==== logic/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    // load width presented by execute
    typedef enum logic [2:0] {
        LOAD_NONE   = 3'd0,
        LOAD_BYTE   = 3'd1,
        LOAD_HALF   = 3'd2,
        LOAD_WORD   = 3'd3,
        LOAD_DOUBLE = 3'd4
    } load_e;

    // store width presented by execute
    typedef enum logic [2:0] {
        STORE_NONE   = 3'd0,
        STORE_BYTE   = 3'd1,
        STORE_HALF   = 3'd2,
        STORE_WORD   = 3'd3,
        STORE_DOUBLE = 3'd4
    } store_e;

    // coprocessor-0 register numbers in use
    typedef enum logic [4:0] {
        CP0_STATUS = 5'd12,
        CP0_CAUSE  = 5'd13,
        CP0_EPC    = 5'd14
    } cp0_reg_e;

    // cause register exception codes
    typedef enum logic [4:0] {
        EXC_INT      = 5'd0,
        EXC_SYSCALL  = 5'd8,
        EXC_RESERVED = 5'd10,
        EXC_OVERFLOW = 5'd12
    } exc_code_e;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/mem_stage_pkg.sv
logic/data_mem.sv
logic/cp0_regs.sv
logic/mem_result_stage.sv
logic/mem_stage.sv
test/mem_stage_tb.sv

// ==== test/mem_stage_cases.txt ====
# name ld st ctl(sgn we mfc0 mtc0 link ovf rsv sys flush eret phit) w_regnum cp0_reg alu sdata
#   pc fetch_pc irq periph_rdata then expected w_data we regnum taken epc inst (ld/st/regs decimal)
sd_100 0 4 00000000000 0 0 100 8877665544332211 400 7f0 00 0 100 0 0 0 0 0
ld_100 4 0 01000000000 5 0 100 0 400 7f0 00 0 8877665544332211 1 5 0 0 0
lb_s 1 0 11000000000 5 0 107 0 400 7f0 00 0 ffffffffffffff88 1 5 0 0 0
lb_u 1 0 01000000000 5 0 107 0 400 7f0 00 0 88 1 5 0 0 0
lh_s 2 0 11000000000 6 0 106 0 400 7f0 00 0 ffffffffffff8877 1 6 0 0 0
lh_u 2 0 01000000000 6 0 106 0 400 7f0 00 0 8877 1 6 0 0 0
lw_s 3 0 11000000000 7 0 104 0 400 7f0 00 0 ffffffff88776655 1 7 0 0 0
lw_u 3 0 01000000000 7 0 104 0 400 7f0 00 0 88776655 1 7 0 0 0
sb_201 0 1 00000000000 0 0 201 123456a5 400 7f0 00 0 201 0 0 0 0 0
sh_202 0 2 00000000000 0 0 202 ffffc3b4 400 7f0 00 0 202 0 0 0 0 0
sw_204 0 3 00000000000 0 0 204 11223344deadbeef 400 7f0 00 0 204 0 0 0 0 0
ld_200 4 0 01000000000 9 0 200 0 400 7f0 00 0 deadbeefc3b4a500 1 9 0 0 0
ld_wrap 4 0 01000000000 10 0 900 0 400 7f0 00 0 8877665544332211 1 10 0 0 0
sd_flush 0 4 00000000100 0 0 300 0123456789abcdef 400 7f0 00 0 300 0 0 0 0 0
sd_phit 0 4 00000000001 0 0 300 0123456789abcdef 400 7f0 00 0 300 0 0 0 0 0
ld_300 4 0 01000000000 3 0 300 0 400 7f0 00 0 0 1 3 0 0 0
lb_phit 1 0 11000000001 3 0 100 0 400 7f0 00 123456789abcdef0 fffffffffffffff0 1 3 0 0 0
lw_phit 3 0 01000000001 3 0 100 0 400 7f0 00 123456789abcdef0 9abcdef0 1 3 0 0 0
link_pri 4 0 01101000000 31 12 100 0 500 7f0 00 0 504 1 31 0 0 0
mtc0_epc 0 0 00010000000 0 14 0 abc 400 7f0 00 0 0 0 0 0 0 0
mfc0_pri 4 0 01100000000 2 14 100 0 400 7f0 00 0 abc 1 2 0 abc 0
alu_only 0 0 00000000000 9 0 123456789 0 400 7f0 00 0 123456789 0 9 0 abc 0
ovf_exc 0 0 00000100000 0 0 0 0 600 7f0 00 0 0 0 0 1 abc 0
cause_ovf 0 0 01100000000 4 13 0 0 604 7f0 00 0 30 1 4 0 600 0
sys_in_exl 0 0 00000001000 0 0 0 0 700 7f0 00 0 0 0 0 0 600 0
eret_1 0 0 00000000010 0 0 0 0 400 7f0 00 0 0 0 0 0 600 0
sys_exc 0 0 00000001000 0 0 0 0 800 7f0 00 0 0 0 0 1 600 0
epc_sys 0 0 01100000000 6 14 0 0 400 7f0 00 0 800 1 6 0 800 0
cause_sys 0 0 01100000000 6 13 0 0 400 7f0 05 0 520 1 6 0 800 0
eret_2 0 0 00000000010 0 0 0 0 400 7f0 00 0 0 0 0 0 800 0
rsv_exc 0 0 00000011000 0 0 0 0 900 7f0 00 0 0 0 0 1 800 0
cause_rsv 0 0 01100000000 6 13 0 0 400 7f0 00 0 28 1 6 0 900 0
eret_3 0 0 00000000010 0 0 0 0 400 7f0 00 0 0 0 0 0 900 0
mtc0_status 0 0 00010000000 0 12 0 401 400 7f0 00 0 0 0 0 0 900 0
irq_masked 0 0 00000000000 0 0 0 0 400 7f0 08 0 0 0 0 0 900 0
irq_taken 0 0 00000000000 0 0 0 0 a00 7f0 04 0 0 0 0 1 900 0
status_exl 0 0 01100000000 6 12 0 0 400 7f0 04 0 403 1 6 0 a00 0
eret_4 0 0 00000000010 0 0 0 0 400 7f0 00 0 0 0 0 0 a00 0
sw_inst 0 3 00000000000 0 0 40 2402000a 400 7f0 00 0 40 0 0 0 a00 0
fetch_40 0 0 00000000000 0 0 0 0 400 40 00 0 0 0 0 0 a00 2402000a
sb_inst 0 1 00000000000 0 0 41 ff 400 40 00 0 41 0 0 0 a00 2402ff0a

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_tb;

    localparam int    PERIOD       = 40;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    RESET_CYCLES = 10;
    localparam string CASE_FILE    = "test/mem_stage_cases.txt";

    logic                    clock;
    logic                    reset;
    logic [`MEM_XLEN-1:0]    alu_out;
    logic [`MEM_XLEN-1:0]    store_data;
    mem_stage_pkg::load_e    load_type;
    logic                    load_signed;
    mem_stage_pkg::store_e   store_type;
    logic [4:0]              w_regnum;
    logic                    write_enable;
    logic                    mfc0;
    logic                    mtc0;
    mem_stage_pkg::cp0_reg_e cp0_reg;
    logic                    link;
    logic [`MEM_XLEN-1:0]    pc;
    logic [`MEM_XLEN-1:0]    pc4;
    logic                    overflow;
    logic                    reserved_inst;
    logic                    syscall;
    logic [`MEM_XLEN-1:0]    fetch_pc;
    logic [7:0]              interrupt_sources;
    logic                    flush;
    logic                    eret;
    logic                    periph_hit;
    logic [`MEM_XLEN-1:0]    periph_rdata;
    logic [31:0]             inst;
    logic [`MEM_XLEN-1:0]    w_data;
    logic [4:0]              w_regnum_q;
    logic                    write_enable_q;
    logic [`MEM_XLEN-1:0]    epc_q;
    logic                    taken_handler_q;

    string case_lines[$];
    bit    cases_loaded;

    mem_stage dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected)
        else stop_run($sformatf("ERROR %0s %0s expected %h actual %h",
                                name, field, expected, actual));
    endtask

    task automatic check_outputs(input string name, input logic [63:0] exp_wd,
                                 input logic exp_we, input logic [4:0] exp_rn,
                                 input logic exp_th, input logic [63:0] exp_epc);
        check_value(name, "w_data", exp_wd, w_data);
        check_value(name, "write_enable_q", 64'(exp_we), 64'(write_enable_q));
        check_value(name, "w_regnum_q", 64'(exp_rn), 64'(w_regnum_q));
        check_value(name, "taken_handler_q", 64'(exp_th), 64'(taken_handler_q));
        check_value(name, "epc_q", exp_epc, epc_q);
    endtask

    // reset holds the stage against busy inputs
    task automatic init_inputs();
        alu_out           = 64'h0123_4567_89ab_cdef;
        store_data        = '0;
        load_type         = mem_stage_pkg::LOAD_NONE;
        load_signed       = 1'b0;
        store_type        = mem_stage_pkg::STORE_NONE;
        w_regnum          = 5'd31;
        write_enable      = 1'b1;
        mfc0              = 1'b0;
        mtc0              = 1'b0;
        cp0_reg           = mem_stage_pkg::CP0_STATUS;
        link              = 1'b0;
        pc                = '0;
        pc4               = '0;
        overflow          = 1'b1;
        reserved_inst     = 1'b0;
        syscall           = 1'b0;
        fetch_pc          = '0;
        interrupt_sources = '0;
        flush             = 1'b0;
        eret              = 1'b0;
        periph_hit        = 1'b0;
        periph_rdata      = '0;
    endtask

    // keep every non-comment line as one cycle
    task automatic load_cases();
        int    fd;
        string text;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            stop_run($sformatf("cannot open the case file %0s", CASE_FILE));
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text[0] != "#") begin
                case_lines.push_back(text);
            end
        end
        $fclose(fd);
    endtask

    // drive one line now and check it just after the next rising edge
    task automatic run_case(input string text);
        logic [8*16-1:0] name_bits;
        string           name;
        int              count;
        logic [2:0]      ld;
        logic [2:0]      st;
        logic [10:0]     ctl;
        logic [4:0]      wrn;
        logic [4:0]      cp0;
        logic [63:0]     alu;
        logic [63:0]     sdata;
        logic [63:0]     pc_v;
        logic [63:0]     fpc;
        logic [7:0]      irq;
        logic [63:0]     prd;
        logic [63:0]     exp_wd;
        logic            exp_we;
        logic [4:0]      exp_rn;
        logic            exp_th;
        logic [63:0]     exp_epc;
        logic [31:0]     exp_inst;
        count = $sscanf(text, "%s %d %d %b %d %d %h %h %h %h %h %h %h %d %d %d %h %h",
                        name_bits, ld, st, ctl, wrn, cp0, alu, sdata, pc_v, fpc, irq, prd,
                        exp_wd, exp_we, exp_rn, exp_th, exp_epc, exp_inst);
        if (count != 18) begin
            stop_run($sformatf("malformed line in the case file: %0s", text));
        end
        name = $sformatf("%0s", name_bits);
        alu_out           = alu;
        store_data        = sdata;
        load_type         = mem_stage_pkg::load_e'(ld);
        store_type        = mem_stage_pkg::store_e'(st);
        load_signed       = ctl[10];
        write_enable      = ctl[9];
        mfc0              = ctl[8];
        mtc0              = ctl[7];
        link              = ctl[6];
        overflow          = ctl[5];
        reserved_inst     = ctl[4];
        syscall           = ctl[3];
        flush             = ctl[2];
        eret              = ctl[1];
        periph_hit        = ctl[0];
        w_regnum          = wrn;
        cp0_reg           = mem_stage_pkg::cp0_reg_e'(cp0);
        pc                = pc_v;
        pc4               = pc_v + 64'd4;
        fetch_pc          = fpc;
        interrupt_sources = irq;
        periph_rdata      = prd;
        @(posedge clock);
        #1;
        check_outputs(name, exp_wd, exp_we, exp_rn, exp_th, exp_epc);
        // inst is sampled after the edge, so it already holds this line's store
        check_value(name, "inst", 64'(exp_inst), 64'(inst));
        #(DRIVE_DELAY - 1);
    endtask

    initial begin
        init_inputs();
        reset = 1'b1;
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_outputs("reset", 64'd0, 1'b0, 5'd0, 1'b0, 64'd0);
        foreach (case_lines[i]) begin
            run_case(case_lines[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

    // reset time plus one cycle per case and some slack
    initial begin
        wait (cases_loaded);
        #((case_lines.size() + 20) * PERIOD);
        stop_run("timeout: the cases did not complete in the expected time");
    end

endmodule

`default_nettype wire
